/* compile.f */
+incdir+hdl
+incdir+tb
hdl/mips_isa_pkg.sv
hdl/mips_ctrl_pkg.sv
hdl/control_unit.sv
hdl/alu_control.sv
hdl/id_ex_latch.sv
hdl/decode_top.sv
tb/tb_decode_top.sv

/* Bender.yml */
package:
  name: mips_decode

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mips_isa_pkg.sv
      - hdl/mips_ctrl_pkg.sv
      - hdl/control_unit.sv
      - hdl/alu_control.sv
      - hdl/id_ex_latch.sv
      - hdl/decode_top.sv
  - target: test
    include_dirs:
      - hdl
      - tb
    files:
      - tb/tb_decode_top.sv

/* tb/decode_ref.svh */
// expected id/ex bundle, built from the per-group decode rules.
function automatic id_ex_t decode_ref(input instr_t ins);
    id_ex_t      r;
    logic [15:0] imm16;
    r        = '0;
    imm16    = ins[15:0];
    r.rs     = ins.rs;
    r.rt     = ins.rt;
    r.shamt  = ins.shamt;
    r.target = ins[25:0];
    case (ins.opcode)
        OP_R_TYPE: begin
            r.ctrl.reg_dest  = 1'b1;
            r.ctrl.write_reg = 1'b1;
            r.ctrl.alu_class = CLS_RTYPE;
            case (ins.funct)
                FN_ADDU:         r.alu_op = ALU_ADD;
                FN_SUBU:         r.alu_op = ALU_SUB;
                FN_AND:          r.alu_op = ALU_AND;
                FN_OR:           r.alu_op = ALU_OR;
                FN_XOR:          r.alu_op = ALU_XOR;
                FN_NOR:          r.alu_op = ALU_NOR;
                FN_SLT:          r.alu_op = ALU_SLT;
                FN_SLTU:         r.alu_op = ALU_SLTU;
                FN_SLL, FN_SLLV: r.alu_op = ALU_SLL;
                FN_SRL, FN_SRLV: r.alu_op = ALU_SRL;
                FN_SRA, FN_SRAV: r.alu_op = ALU_SRA;
                FN_JR, FN_JALR: begin
                    r.ctrl.jump      = 1'b1;
                    r.ctrl.link      = (ins.funct == FN_JALR);
                    r.ctrl.write_reg = (ins.funct == FN_JALR); // jr writes nothing.
                end
                default:         r.ctrl.illegal = 1'b1;
            endcase
        end
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
            r.ctrl.mem_read    = 1'b1;
            r.ctrl.mem_to_reg  = 1'b1;
            r.ctrl.write_reg   = 1'b1;
            r.ctrl.alu_src     = 1'b1;
            r.ctrl.signed_load = (ins.opcode inside {OP_LB, OP_LH, OP_LW});
        end
        OP_SB, OP_SH, OP_SW: begin
            r.ctrl.mem_write = 1'b1;
            r.ctrl.alu_src   = 1'b1;
        end
        OP_BEQ, OP_BNE: begin
            r.ctrl.branch    = 1'b1;
            r.ctrl.branch_ne = (ins.opcode == OP_BNE);
            r.ctrl.alu_class = CLS_BRANCH;
            r.alu_op         = ALU_SUB;
        end
        OP_J, OP_JAL: begin
            r.ctrl.jump      = 1'b1;
            r.ctrl.link      = (ins.opcode == OP_JAL);
            r.ctrl.write_reg = (ins.opcode == OP_JAL);
        end
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
            r.ctrl.alu_src   = 1'b1;
            r.ctrl.write_reg = 1'b1;
            r.ctrl.alu_class = CLS_IMM;
            case (ins.opcode)
                OP_SLTI:  r.alu_op = ALU_SLT;
                OP_SLTIU: r.alu_op = ALU_SLTU;
                OP_ANDI:  r.alu_op = ALU_AND;
                OP_ORI:   r.alu_op = ALU_OR;
                OP_XORI:  r.alu_op = ALU_XOR;
                OP_LUI:   r.alu_op = ALU_LUI;
                default:  r.alu_op = ALU_ADD;
            endcase
        end
        default: r.ctrl.illegal = 1'b1;
    endcase
    if (r.ctrl.mem_read || r.ctrl.mem_write) begin
        r.ctrl.mem_size = (ins.opcode inside {OP_LB, OP_LBU, OP_SB}) ? MEM_BYTE :
                          (ins.opcode inside {OP_LH, OP_LHU, OP_SH}) ? MEM_HALF : MEM_WORD;
    end
    r.ctrl.ext = (ins.opcode inside {OP_ANDI, OP_ORI, OP_XORI}) ? EXT_ZERO :
                 (ins.opcode == OP_LUI) ? EXT_UPPER : EXT_SIGN;
    r.imm = (r.ctrl.ext == EXT_ZERO)  ? {16'h0000, imm16} :
            (r.ctrl.ext == EXT_UPPER) ? {imm16, 16'h0000} : {{16{imm16[15]}}, imm16};
    r.wr_reg = (ins.opcode == OP_JAL) ? `MIPS_REG_W'(`MIPS_LINK_REG) :
               r.ctrl.reg_dest ? ins.rd : ins.rt;
    return r;
endfunction

task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
    if (act !== exp) begin
        report_failure($sformatf("Mismatch at %0t: %s expected %h actual %h",
                                 $time, name, exp, act));
    end
endtask

task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
    if (act !== exp) begin
        report_failure($sformatf("Mismatch at %0t: %s expected %0d actual %0d",
                                 $time, name, exp, act));
    end
endtask

task automatic check_imm(input string name, input logic [`MIPS_XLEN-1:0] exp,
                         input logic [`MIPS_XLEN-1:0] act);
    if (act !== exp) begin
        report_failure($sformatf("Mismatch at %0t: %s expected %h actual %h",
                                 $time, name, exp, act));
    end
endtask

task automatic check_idx(input string name, input logic [`MIPS_REG_W-1:0] exp,
                         input logic [`MIPS_REG_W-1:0] act);
    if (act !== exp) begin
        report_failure($sformatf("Mismatch at %0t: %s expected %0d actual %0d",
                                 $time, name, exp, act));
    end
endtask

/* tb/tb_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_settings.svh"

module tb_decode_top;
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    localparam int N_INSTR = 600;
    localparam int LIMIT   = 4 * N_INSTR + 100;

    logic   i_clk;
    logic   i_arst_n;
    logic   i_valid;
    logic   o_ready;
    instr_t i_instr;
    logic   o_valid;
    logic   i_ready;
    id_ex_t o_id_ex;

    id_ex_t exp_q[$];
    id_ex_t held;          // bundle seen one cycle earlier.
    logic   stalled = 1'b0;
    logic   taken   = 1'b0;
    logic   fire;
    int     sent    = 0;
    int     cycles  = 0;
    int     drain;

    decode_top u_dut (.*);

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    `include "decode_ref.svh"

    // known opcodes and functs over random fields, plus raw encodings.
    function automatic instr_t random_instr();
        instr_t  ins;
        opcode_e op;
        funct_e  fn;
        ins = instr_t'($urandom);
        op  = op.first();
        fn  = fn.first();
        repeat ($urandom % op.num()) op = op.next();
        repeat ($urandom % fn.num()) fn = fn.next();
        case ($urandom % 8)
            0:       ;                        // raw word with a mostly unknown opcode.
            1, 2:    ins.opcode = OP_R_TYPE;
            default: ins.opcode = op;
        endcase
        if ($urandom % 8 != 0) begin
            ins.funct = fn;
        end
        return ins;
    endfunction

    task automatic compare_bundle(input id_ex_t exp, input id_ex_t act);
        check_ctrl("o_id_ex.ctrl", exp.ctrl, act.ctrl);
        check_alu("o_id_ex.alu_op", exp.alu_op, act.alu_op);
        check_imm("o_id_ex.imm", exp.imm, act.imm);
        check_imm("o_id_ex.target", `MIPS_XLEN'(exp.target), `MIPS_XLEN'(act.target));
        check_idx("o_id_ex.rs", exp.rs, act.rs);
        check_idx("o_id_ex.rt", exp.rt, act.rt);
        check_idx("o_id_ex.wr_reg", exp.wr_reg, act.wr_reg);
        check_idx("o_id_ex.shamt", exp.shamt, act.shamt);
    endtask

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    initial begin
        void'($urandom(32'ha9d04933));
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_ready  = 1'b0;
        i_instr  = '0;
        repeat (2) @(posedge i_clk);
        i_arst_n <= 1'b1;
        @(negedge i_clk);
        if (o_valid !== 1'b0 || o_ready !== 1'b1) begin
            report_failure("after reset o_valid is not low or o_ready is not high");
        end
        // first half random valid and ready, second half both held high.
        while (sent < N_INSTR) begin
            @(negedge i_clk);
            fire = i_valid && o_ready;
            @(posedge i_clk);
            sent = sent + fire;
            if (fire || !i_valid) begin
                i_valid <= (sent < N_INSTR) && ((sent >= N_INSTR / 2) || ($urandom % 4 != 0));
                i_instr <= random_instr();
            end
            i_ready <= (sent >= N_INSTR / 2) || ($urandom % 2 == 1);
        end
        i_ready <= 1'b1;
        drain = 0;
        while (exp_q.size() != 0 && drain < 8) begin
            @(posedge i_clk);
            drain++;
        end
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d accepted instructions never came out", exp_q.size()));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    // sampled mid-cycle while inputs and outputs are settled.
    always @(negedge i_clk) begin
        if (i_arst_n) begin
            if (taken && o_valid !== 1'b1) begin
                report_failure("accepted instruction did not appear one cycle later");
            end
            if (stalled && (o_valid !== 1'b1 || o_id_ex !== held)) begin
                report_failure($sformatf(
                    "Mismatch at %0t: o_id_ex under back-pressure expected %h actual %h",
                    $time, held, o_id_ex));
            end
            if (o_valid !== (exp_q.size() != 0)) begin
                report_failure($sformatf("Mismatch at %0t: o_valid expected %0b actual %0b",
                                         $time, exp_q.size() != 0, o_valid));
            end
            if (o_ready !== ((exp_q.size() == 0) || i_ready)) begin
                report_failure($sformatf("Mismatch at %0t: o_ready expected %0b actual %0b",
                                         $time, (exp_q.size() == 0) || i_ready, o_ready));
            end
            if (o_valid && i_ready) begin
                if (exp_q.size() == 0) begin
                    report_failure("output transfer without any accepted instruction");
                end else begin
                    compare_bundle(exp_q.pop_front(), o_id_ex);
                end
            end
            if (i_valid && o_ready) begin
                exp_q.push_back(decode_ref(i_instr));
            end
            stalled = o_valid && !i_ready;
            taken   = i_valid && o_ready;
            held    = o_id_ex;
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            report_failure($sformatf("timeout after %0d cycles, %0d of %0d instructions sent",
                                     cycles, sent, N_INSTR));
        end
    end

endmodule

`default_nettype wire

/* hdl/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  wire                       i_clk,
    input  wire                       i_arst_n,
    input  wire                       i_valid,
    output logic                      o_ready,
    input  wire mips_isa_pkg::instr_t i_instr,
    output logic                      o_valid,
    input  wire                       i_ready,
    output mips_ctrl_pkg::id_ex_t     o_id_ex
);
    import mips_ctrl_pkg::*;

    ctrl_t    ctrl;
    alu_dec_t alu_dec;

    // both decoders see the same instruction in parallel.
    control_unit u_control_unit (
        .i_instr (i_instr),
        .o_ctrl  (ctrl)
    );

    alu_control u_alu_control (
        .i_instr   (i_instr),
        .o_alu_dec (alu_dec)
    );

    id_ex_latch u_id_ex_latch (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_valid   (i_valid),
        .i_instr   (i_instr),
        .i_ctrl    (ctrl),
        .i_alu_dec (alu_dec),
        .i_ready   (i_ready),
        .o_ready   (o_ready),
        .o_valid   (o_valid),
        .o_id_ex   (o_id_ex)
    );

endmodule

`default_nettype wire

/* hdl/id_ex_latch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_settings.svh"

module id_ex_latch (
    input  wire                         i_clk,
    input  wire                         i_arst_n,
    input  wire                         i_valid,
    input  wire mips_isa_pkg::instr_t   i_instr,
    input  wire mips_ctrl_pkg::ctrl_t   i_ctrl,
    input  wire mips_ctrl_pkg::alu_dec_t i_alu_dec,
    input  wire                         i_ready,
    output logic                        o_ready,
    output logic                        o_valid,
    output mips_ctrl_pkg::id_ex_t       o_id_ex
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    logic [IMM_W-1:0]       imm;
    logic [`MIPS_XLEN-1:0]  imm_ext;
    logic [`MIPS_REG_W-1:0] wr_reg;
    ctrl_t                  ctrl;
    alu_op_e                alu_op;
    id_ex_t                 bundle_d;
    id_ex_t                 bundle_q;
    logic                   valid_q;

    assign imm = i_instr[IMM_W-1:0];

    always_comb begin
        case (i_ctrl.ext)
            EXT_ZERO:  imm_ext = {{(`MIPS_XLEN-IMM_W){1'b0}}, imm};
            EXT_UPPER: imm_ext = {imm, {(`MIPS_XLEN-IMM_W){1'b0}}};
            default:   imm_ext = {{(`MIPS_XLEN-IMM_W){imm[IMM_W-1]}}, imm};
        endcase
    end

    always_comb begin
        ctrl = i_ctrl;
        case (i_ctrl.alu_class)
            CLS_RTYPE:  alu_op = i_alu_dec.funct_op;
            CLS_IMM:    alu_op = i_alu_dec.imm_op;
            CLS_BRANCH: alu_op = ALU_SUB;
            default:    alu_op = ALU_ADD;
        endcase
        if (i_ctrl.alu_class == CLS_RTYPE) begin
            ctrl.illegal = i_ctrl.illegal | i_alu_dec.funct_illegal;
            ctrl.jump    = i_alu_dec.jump_reg;
            ctrl.link    = i_alu_dec.link_reg;
            if (i_alu_dec.jump_reg && !i_alu_dec.link_reg) begin
                ctrl.write_reg = 1'b0; // jr has no destination.
            end
        end
    end

    // jal links to the fixed register, jalr goes through rd.
    assign wr_reg = i_ctrl.link   ? `MIPS_REG_W'(`MIPS_LINK_REG) :
                    i_ctrl.reg_dest ? i_instr.rd : i_instr.rt;

    always_comb begin
        bundle_d.ctrl   = ctrl;
        bundle_d.alu_op = alu_op;
        bundle_d.rs     = i_instr.rs;
        bundle_d.rt     = i_instr.rt;
        bundle_d.wr_reg = wr_reg;
        bundle_d.shamt  = i_instr.shamt;
        bundle_d.imm    = imm_ext;
        bundle_d.target = i_instr[JTGT_W-1:0];
    end

    assign o_ready = !valid_q || i_ready; // empty or draining this cycle.

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= 1'b0;
        end else if (o_ready) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready) begin
            bundle_q <= bundle_d;
        end
    end

    assign o_valid = valid_q;
    assign o_id_ex = bundle_q;

    a_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_id_ex))
        else $error("id_ex_latch: bundle changed under back-pressure");

endmodule

`default_nettype wire

/* hdl/alu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_control (
    input  wire mips_isa_pkg::instr_t i_instr,
    output mips_ctrl_pkg::alu_dec_t   o_alu_dec
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    alu_dec_t dec;

    // funct side, meaningful only for r-type.
    always_comb begin
        dec.funct_op       = ALU_ADD;
        dec.shamt_from_reg = 1'b0;
        dec.funct_illegal  = 1'b0;
        dec.jump_reg       = 1'b0;
        dec.link_reg       = 1'b0;
        case (i_instr.funct)
            FN_ADDU: dec.funct_op = ALU_ADD;
            FN_SUBU: dec.funct_op = ALU_SUB;
            FN_AND:  dec.funct_op = ALU_AND;
            FN_OR:   dec.funct_op = ALU_OR;
            FN_XOR:  dec.funct_op = ALU_XOR;
            FN_NOR:  dec.funct_op = ALU_NOR;
            FN_SLT:  dec.funct_op = ALU_SLT;
            FN_SLTU: dec.funct_op = ALU_SLTU;
            FN_SLL:  dec.funct_op = ALU_SLL;
            FN_SRL:  dec.funct_op = ALU_SRL;
            FN_SRA:  dec.funct_op = ALU_SRA;
            FN_SLLV: begin
                dec.funct_op       = ALU_SLL;
                dec.shamt_from_reg = 1'b1; // amount from rs.
            end
            FN_SRLV: begin
                dec.funct_op       = ALU_SRL;
                dec.shamt_from_reg = 1'b1;
            end
            FN_SRAV: begin
                dec.funct_op       = ALU_SRA;
                dec.shamt_from_reg = 1'b1;
            end
            FN_JR: begin
                dec.jump_reg = 1'b1;
            end
            FN_JALR: begin
                dec.jump_reg = 1'b1;
                dec.link_reg = 1'b1;
            end
            default: dec.funct_illegal = 1'b1;
        endcase
    end

    // opcode side for immediate alu instructions.
    always_comb begin
        case (i_instr.opcode)
            OP_ADDI, OP_ADDIU: dec.imm_op = ALU_ADD;
            OP_ANDI:           dec.imm_op = ALU_AND;
            OP_ORI:            dec.imm_op = ALU_OR;
            OP_XORI:           dec.imm_op = ALU_XOR;
            OP_SLTI:           dec.imm_op = ALU_SLT;
            OP_SLTIU:          dec.imm_op = ALU_SLTU;
            OP_LUI:            dec.imm_op = ALU_LUI;
            default:           dec.imm_op = ALU_ADD;
        endcase
    end

    assign o_alu_dec = dec;

endmodule

`default_nettype wire

/* hdl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  wire mips_isa_pkg::instr_t i_instr,
    output mips_ctrl_pkg::ctrl_t      o_ctrl
);
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;

    ctrl_t ctrl;

    always_comb begin
        ctrl = '0; // unknown opcodes keep everything cleared.
        case (i_instr.opcode)
            OP_R_TYPE: begin
                ctrl.reg_dest  = 1'b1;
                ctrl.write_reg = 1'b1;
                ctrl.alu_class = CLS_RTYPE;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU: begin
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.write_reg  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_class  = CLS_MEM;
                ctrl.ext        = EXT_SIGN;
                ctrl.signed_load = (i_instr.opcode == OP_LB) ||
                                   (i_instr.opcode == OP_LH) ||
                                   (i_instr.opcode == OP_LW);
                if (i_instr.opcode == OP_LB || i_instr.opcode == OP_LBU) begin
                    ctrl.mem_size = MEM_BYTE;
                end else if (i_instr.opcode == OP_LH || i_instr.opcode == OP_LHU) begin
                    ctrl.mem_size = MEM_HALF;
                end else begin
                    ctrl.mem_size = MEM_WORD;
                end
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_class = CLS_MEM;
                ctrl.ext       = EXT_SIGN;
                if (i_instr.opcode == OP_SB) begin
                    ctrl.mem_size = MEM_BYTE;
                end else if (i_instr.opcode == OP_SH) begin
                    ctrl.mem_size = MEM_HALF;
                end else begin
                    ctrl.mem_size = MEM_WORD;
                end
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (i_instr.opcode == OP_BNE);
                ctrl.alu_class = CLS_BRANCH;
                ctrl.ext       = EXT_SIGN; // word offset.
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl.alu_src   = 1'b1;
                ctrl.write_reg = 1'b1;
                ctrl.alu_class = CLS_IMM;
                ctrl.ext       = EXT_SIGN;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.write_reg = 1'b1;
                ctrl.alu_class = CLS_IMM;
                ctrl.ext       = EXT_ZERO; // logical ops take raw bits.
            end
            OP_LUI: begin
                ctrl.alu_src   = 1'b1;
                ctrl.write_reg = 1'b1;
                ctrl.alu_class = CLS_IMM;
                ctrl.ext       = EXT_UPPER;
            end
            OP_J, OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = (i_instr.opcode == OP_JAL);
                ctrl.write_reg = (i_instr.opcode == OP_JAL); // return address.
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

    assign o_ctrl = ctrl;

endmodule

`default_nettype wire

/* hdl/mips_ctrl_pkg.sv */
`default_nettype none

`include "mips_settings.svh"

package mips_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // source of the final alu operation.
    typedef enum logic [1:0] {
        CLS_MEM    = 2'd0, // address add.
        CLS_BRANCH = 2'd1, // compare by subtract.
        CLS_RTYPE  = 2'd2, // from funct.
        CLS_IMM    = 2'd3  // from opcode.
    } alu_class_e;

    typedef enum logic [1:0] {
        EXT_SIGN  = 2'd0,
        EXT_ZERO  = 2'd1,
        EXT_UPPER = 2'd2
    } ext_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic       mem_to_reg;  // wb.
        logic       write_reg;
        logic       mem_read;    // mem.
        logic       mem_write;
        logic       branch;
        logic       branch_ne;
        logic       signed_load;
        mem_size_e  mem_size;
        logic       reg_dest;    // ex.
        logic       alu_src;
        alu_class_e alu_class;
        ext_e       ext;
        logic       jump;
        logic       link;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        alu_op_e funct_op;
        alu_op_e imm_op;
        logic    shamt_from_reg;
        logic    funct_illegal;
        logic    jump_reg;
        logic    link_reg;
    } alu_dec_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        alu_op_e                alu_op;
        logic [`MIPS_REG_W-1:0] rs;
        logic [`MIPS_REG_W-1:0] rt;
        logic [`MIPS_REG_W-1:0] wr_reg;
        logic [4:0]             shamt;
        logic [`MIPS_XLEN-1:0]  imm;
        logic [25:0]            target;
    } id_ex_t;

endpackage

`default_nettype wire

/* hdl/mips_isa_pkg.sv */
`default_nettype none

`include "mips_settings.svh"

package mips_isa_pkg;

    localparam int IMM_W  = 16; // i-type immediate width.
    localparam int JTGT_W = 26; // j-type target width.

    typedef enum logic [5:0] {
        OP_R_TYPE = 6'b000000,
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_ADDI   = 6'b001000,
        OP_ADDIU  = 6'b001001,
        OP_SLTI   = 6'b001010,
        OP_SLTIU  = 6'b001011,
        OP_ANDI   = 6'b001100,
        OP_ORI    = 6'b001101,
        OP_XORI   = 6'b001110,
        OP_LUI    = 6'b001111,
        OP_LB     = 6'b100000,
        OP_LH     = 6'b100001,
        OP_LW     = 6'b100011,
        OP_LBU    = 6'b100100,
        OP_LHU    = 6'b100101,
        OP_LWU    = 6'b100111,
        OP_SB     = 6'b101000,
        OP_SH     = 6'b101001,
        OP_SW     = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // immediate is the low 16 bits, jump target the low 26.
    typedef struct packed {
        opcode_e                opcode;
        logic [`MIPS_REG_W-1:0] rs;
        logic [`MIPS_REG_W-1:0] rt;
        logic [`MIPS_REG_W-1:0] rd;
        logic [4:0]             shamt;
        funct_e                 funct;
    } instr_t;

endpackage

`default_nettype wire

/* hdl/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// datapath word width.
`define MIPS_XLEN 32

// register file index width.
`define MIPS_REG_W 5

// register written by jal.
`define MIPS_LINK_REG 31

`endif
